//--- common/filereg_cfg.svh
`ifndef FILEREG_CFG_SVH
`define FILEREG_CFG_SVH

// ------------------------------
// register file geometry
// ------------------------------
`define FILEREG_DEPTH          8
`define FILEREG_ENTRY_WIDTH    16
`define FILEREG_ID_WIDTH       3

// command codes, one bit wide
`define FILEREG_CMD_WIDTH      1
`define FILEREG_CMD_READ       1'b0
`define FILEREG_CMD_WRITE      1'b1

// ------------------------------
// mesh and virtual networks
// ------------------------------
`define FILEREG_NUM_VNS        2
`define FILEREG_LBDR_BITS      12
`define FILEREG_NODE_ID_WIDTH  4
`define FILEREG_DIM_X          4
`define FILEREG_DIM_Y          4
`define FILEREG_DIM_X_WIDTH    2
`define FILEREG_DIM_Y_WIDTH    2

// lbdr bit positions, routing bits on top
`define FILEREG_LBDR_RNE       11
`define FILEREG_LBDR_RNW       10
`define FILEREG_LBDR_REN       9
`define FILEREG_LBDR_RES       8
`define FILEREG_LBDR_RWN       7
`define FILEREG_LBDR_RWS       6
`define FILEREG_LBDR_RSE       5
`define FILEREG_LBDR_RSW       4
// connectivity bits in the low nibble
`define FILEREG_LBDR_CN        3
`define FILEREG_LBDR_CE        2
`define FILEREG_LBDR_CW        1
`define FILEREG_LBDR_CS        0

`endif

//--- common/filereg_pkg.sv
`include "filereg_cfg.svh"

package filereg_pkg;

  // ------------------------------
  // scalar fields
  // ------------------------------
  typedef logic [`FILEREG_ENTRY_WIDTH-1:0]   entry_t;
  typedef logic [`FILEREG_ID_WIDTH-1:0]      entry_id_t;
  typedef logic [`FILEREG_CMD_WIDTH-1:0]     cmd_t;
  // node id doubles as the requester id of a read
  typedef logic [`FILEREG_NODE_ID_WIDTH-1:0] node_id_t;

  // one lbdr set and the flat bus of all vns, vn 0 in the low bits
  typedef logic [`FILEREG_LBDR_BITS-1:0] lbdr_t;
  typedef logic [`FILEREG_NUM_VNS*`FILEREG_LBDR_BITS-1:0] lbdr_bus_t;

  // ------------------------------
  // stream words
  // ------------------------------
  // command word is {cmd, entry id, payload}
  typedef logic [`FILEREG_CMD_WIDTH+`FILEREG_ID_WIDTH+`FILEREG_ENTRY_WIDTH-1:0] op_word_t;
  // reply word is {source id, data}
  typedef logic [`FILEREG_NODE_ID_WIDTH+`FILEREG_ENTRY_WIDTH-1:0] reply_word_t;

  // reply slot occupancy
  typedef enum logic {
    RET_EMPTY = 1'b0,
    RET_FULL  = 1'b1
  } ret_state_e;

endpackage

//--- filereg/lbdr_xy_defaults.sv
`timescale 1ns/1ps

`include "filereg_cfg.svh"

module lbdr_xy_defaults import filereg_pkg::*; #(
  parameter int unsigned NODE_ID = 0
) (
  output lbdr_t default_o
);

  // ------------------------------
  // node position in the mesh
  // ------------------------------
  // ids grow eastward in x and northward in y
  localparam node_id_t NODE = node_id_t'(NODE_ID);
  localparam logic [`FILEREG_DIM_X_WIDTH-1:0] X_POS = NODE[`FILEREG_DIM_X_WIDTH-1:0];
  localparam logic [`FILEREG_DIM_Y_WIDTH-1:0] Y_POS =
    NODE[`FILEREG_DIM_X_WIDTH +: `FILEREG_DIM_Y_WIDTH];

  // mesh edge flags
  localparam bit ON_WEST  = (X_POS == 0);
  localparam bit ON_EAST  = (X_POS == `FILEREG_DIM_X - 1);
  localparam bit ON_SOUTH = (Y_POS == 0);
  localparam bit ON_NORTH = (Y_POS == `FILEREG_DIM_Y - 1);

  // ------------------------------
  // default lbdr set
  // ------------------------------
  always_comb begin
    default_o = '0;

    // xy routing is identical in every node
    // only the turns out of east and west are allowed
    default_o[`FILEREG_LBDR_RNE] = 1'b0;
    default_o[`FILEREG_LBDR_RNW] = 1'b0;
    default_o[`FILEREG_LBDR_REN] = 1'b1;
    default_o[`FILEREG_LBDR_RES] = 1'b1;
    default_o[`FILEREG_LBDR_RWN] = 1'b1;
    default_o[`FILEREG_LBDR_RWS] = 1'b1;
    default_o[`FILEREG_LBDR_RSE] = 1'b0;
    default_o[`FILEREG_LBDR_RSW] = 1'b0;

    // no link leaves the mesh border
    default_o[`FILEREG_LBDR_CN] = !ON_NORTH;
    default_o[`FILEREG_LBDR_CE] = !ON_EAST;
    default_o[`FILEREG_LBDR_CW] = !ON_WEST;
    default_o[`FILEREG_LBDR_CS] = !ON_SOUTH;
  end

endmodule

//--- filereg/filereg_array.sv
`timescale 1ns/1ps

`include "filereg_cfg.svh"

module filereg_array import filereg_pkg::*; #(
  parameter int unsigned NODE_ID = 0
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      wr_en_i,
  input  entry_id_t entry_id_i,
  input  entry_t    wr_data_i,
  output entry_t    rd_data_o,
  output lbdr_bus_t lbdr_bits_bus_o
);

  localparam int PAD_WIDTH = `FILEREG_ENTRY_WIDTH - `FILEREG_LBDR_BITS;

  // register storage
  entry_t regs_q [`FILEREG_DEPTH];

  // xy defaults for this node
  lbdr_t lbdr_default;

  lbdr_xy_defaults #(
    .NODE_ID(NODE_ID)
  ) u_defaults (
    .default_o(lbdr_default)
  );

  // ------------------------------
  // write port
  // ------------------------------
  // vn entries come up with the xy set, the rest with zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `FILEREG_DEPTH; i++) begin
        if (i < `FILEREG_NUM_VNS) begin
          regs_q[i] <= {{PAD_WIDTH{1'b0}}, lbdr_default};
        end else begin
          regs_q[i] <= '0;
        end
      end
    end else if (wr_en_i) begin
      regs_q[entry_id_i] <= wr_data_i;
    end
  end

  // read port, no latency
  assign rd_data_o = regs_q[entry_id_i];

  // ------------------------------
  // lbdr output bus
  // ------------------------------
  // upper entry bits are not routed out
  for (genvar vn = 0; vn < `FILEREG_NUM_VNS; vn++) begin : g_lbdr_bus
    assign lbdr_bits_bus_o[vn*`FILEREG_LBDR_BITS +: `FILEREG_LBDR_BITS] =
      regs_q[vn][`FILEREG_LBDR_BITS-1:0];
  end

  // a write never lands on an unknown entry
  a_wr_id_known: assert property (
    @(posedge clk_i) disable iff (rst_i) wr_en_i |-> !$isunknown(entry_id_i)
  );

endmodule

//--- rtl/op_control.sv
`timescale 1ns/1ps

`include "filereg_cfg.svh"

module op_control import filereg_pkg::*; (
  input  logic      operation_tvalid_i,
  input  op_word_t  operation_tdata_i,
  input  logic      slot_free_i,
  output logic      operation_tready_o,
  output logic      wr_en_o,
  output logic      rd_en_o,
  output entry_id_t entry_id_o,
  output entry_t    wr_data_o,
  output node_id_t  src_id_o
);

  // ------------------------------
  // command word fields
  // ------------------------------
  localparam int DATA_MSB = `FILEREG_ENTRY_WIDTH - 1;
  localparam int ID_LSB   = `FILEREG_ENTRY_WIDTH;
  localparam int ID_MSB   = ID_LSB + `FILEREG_ID_WIDTH - 1;
  localparam int CMD_LSB  = ID_MSB + 1;
  localparam int CMD_MSB  = CMD_LSB + `FILEREG_CMD_WIDTH - 1;

  cmd_t   cmd;
  entry_t payload;
  logic   is_write;
  logic   is_read;
  logic   accept;

  assign cmd        = operation_tdata_i[CMD_MSB:CMD_LSB];
  assign entry_id_o = operation_tdata_i[ID_MSB:ID_LSB];
  assign payload    = operation_tdata_i[DATA_MSB:0];

  assign is_write = (cmd == `FILEREG_CMD_WRITE);
  assign is_read  = (cmd == `FILEREG_CMD_READ);

  // ------------------------------
  // acceptance
  // ------------------------------
  // writes always pass
  // reads wait until the reply slot can take them
  assign operation_tready_o = is_write || (is_read && slot_free_i);
  assign accept             = operation_tvalid_i && operation_tready_o;

  // strobes only on a real transfer
  assign wr_en_o = accept && is_write;
  assign rd_en_o = accept && is_read;

  // write data is the whole payload
  assign wr_data_o = payload;
  // on a read the requester id sits in the low payload bits
  assign src_id_o  = payload[`FILEREG_NODE_ID_WIDTH-1:0];

endmodule

//--- rtl/read_return.sv
`timescale 1ns/1ps

module read_return import filereg_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        rd_en_i,
  input  entry_t      rd_data_i,
  input  node_id_t    src_id_i,
  input  logic        register_tready_i,
  output logic        slot_free_o,
  output logic        register_tvalid_o,
  output reply_word_t register_tdata_o
);

  ret_state_e  state_q;
  ret_state_e  state_d;
  reply_word_t reply_q;
  logic        drain;

  // reply leaves the slot this cycle
  assign drain = (state_q == RET_FULL) && register_tready_i;

  // empty slot or one that drains now can take a read
  assign slot_free_o = (state_q == RET_EMPTY) || drain;

  // ------------------------------
  // slot fsm
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      RET_EMPTY: begin
        if (rd_en_i) begin
          state_d = RET_FULL;
        end
      end
      RET_FULL: begin
        // a read in the drain cycle refills without a bubble
        if (drain && !rd_en_i) begin
          state_d = RET_EMPTY;
        end
      end
      default: begin
        state_d = RET_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= RET_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // data captured at accept so later writes do not reach it
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      reply_q <= {src_id_i, rd_data_i};
    end
  end

  assign register_tvalid_o = (state_q == RET_FULL);
  assign register_tdata_o  = reply_q;

  // ------------------------------
  // checks
  // ------------------------------
  // stalled reply keeps its word
  a_reply_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (register_tvalid_o && !register_tready_i) |=> $stable(register_tdata_o)
  );

  // the command side must hold reads off a full slot
  a_no_overrun: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rd_en_i |-> ((state_q == RET_EMPTY) || register_tready_i)
  );

endmodule

//--- rtl/filereg_top.sv
`timescale 1ns/1ps

module filereg_top import filereg_pkg::*; #(
  // node 5 sits at x 1 y 1 and touches no edge
  parameter int unsigned NODE_ID = 5
) (
  input  logic        clk_i,
  input  logic        rst_i,
  // command stream
  input  logic        operation_tvalid_i,
  input  op_word_t    operation_tdata_i,
  output logic        operation_tready_o,
  // reply stream
  input  logic        register_tready_i,
  output logic        register_tvalid_o,
  output reply_word_t register_tdata_o,
  // routing configuration to the router
  output lbdr_bus_t   lbdr_bits_bus_o
);

  // ------------------------------
  // internal wires
  // ------------------------------
  logic      wr_en;
  logic      rd_en;
  entry_id_t entry_id;
  entry_t    wr_data;
  entry_t    rd_data;
  node_id_t  src_id;
  logic      slot_free;

  // command decode and acceptance
  op_control u_op_control (
    .operation_tvalid_i(operation_tvalid_i),
    .operation_tdata_i (operation_tdata_i),
    .slot_free_i       (slot_free),
    .operation_tready_o(operation_tready_o),
    .wr_en_o           (wr_en),
    .rd_en_o           (rd_en),
    .entry_id_o        (entry_id),
    .wr_data_o         (wr_data),
    .src_id_o          (src_id)
  );

  // storage with xy reset defaults
  filereg_array #(
    .NODE_ID(NODE_ID)
  ) u_filereg_array (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wr_en_i        (wr_en),
    .entry_id_i     (entry_id),
    .wr_data_i      (wr_data),
    .rd_data_o      (rd_data),
    .lbdr_bits_bus_o(lbdr_bits_bus_o)
  );

  // one deep reply slot
  read_return u_read_return (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .rd_en_i          (rd_en),
    .rd_data_i        (rd_data),
    .src_id_i         (src_id),
    .register_tready_i(register_tready_i),
    .slot_free_o      (slot_free),
    .register_tvalid_o(register_tvalid_o),
    .register_tdata_o (register_tdata_o)
  );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset released on a rising edge, like any other input
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- tb/tb_filereg.sv
`timescale 1ns/1ps

`include "filereg_cfg.svh"

module tb_filereg import filereg_pkg::*; ();

  localparam int unsigned NODE_ID = 5;
  localparam int N_RANDOM = 400;
  localparam int LB = `FILEREG_LBDR_BITS;
  // rough cycle budget of all five tests
  localparam int PLANNED_CYCLES = 10 + 3*`FILEREG_DEPTH + 5*`FILEREG_DEPTH + 40 + 3*N_RANDOM;

  logic        clk;
  logic        rst;
  logic        operation_tvalid;
  op_word_t    operation_tdata;
  logic        operation_tready;
  logic        register_tready;
  logic        register_tvalid;
  reply_word_t register_tdata;
  lbdr_bus_t   lbdr_bits_bus;

  // reference state
  entry_t      model [`FILEREG_DEPTH];
  reply_word_t exp_q [$];
  int          seed = 12;
  logic        random_ready;
  int          pass_count = 0;
  int          fail_count = 0;
  int          reads_seen = 0;
  int          replies_seen = 0;

  tb_clock_gen u_clock_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  filereg_top #(
    .NODE_ID(NODE_ID)
  ) u_dut (
    .clk_i             (clk),
    .rst_i             (rst),
    .operation_tvalid_i(operation_tvalid),
    .operation_tdata_i (operation_tdata),
    .operation_tready_o(operation_tready),
    .register_tready_i (register_tready),
    .register_tvalid_o (register_tvalid),
    .register_tdata_o  (register_tdata),
    .lbdr_bits_bus_o   (lbdr_bits_bus)
  );

  // ------------------------------
  // reference model
  // ------------------------------
  // xy value after reset, routing 0x03c0 plus the links that stay inside the mesh
  function automatic entry_t reset_entry(input int id);
    entry_t val;
    int     x;
    int     y;
    val = '0;
    x = NODE_ID % `FILEREG_DIM_X;
    y = NODE_ID / `FILEREG_DIM_X;
    if (id < `FILEREG_NUM_VNS) begin
      val = 16'h03c0;
      val[`FILEREG_LBDR_CN] = (y != `FILEREG_DIM_Y - 1);
      val[`FILEREG_LBDR_CE] = (x != `FILEREG_DIM_X - 1);
      val[`FILEREG_LBDR_CW] = (x != 0);
      val[`FILEREG_LBDR_CS] = (y != 0);
    end
    return val;
  endfunction

  // reply a read would get right now
  function automatic reply_word_t expected_reply(input entry_id_t id, input node_id_t src);
    return {src, model[id]};
  endfunction

  // low 12 bits of each vn entry, vn 0 lowest
  function automatic lbdr_bus_t expected_bus();
    lbdr_bus_t bus;
    for (int vn = 0; vn < `FILEREG_NUM_VNS; vn++) begin
      bus[vn*LB +: LB] = model[vn][LB-1:0];
    end
    return bus;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // ------------------------------
  // scoreboard
  // ------------------------------
  // reply side first, then the command accepted at the same edge
  always @(posedge clk) begin
    op_word_t word;
    if (rst) begin
      for (int i = 0; i < `FILEREG_DEPTH; i++) begin
        model[i] = reset_entry(i);
      end
      exp_q.delete();
    end else begin
      if (register_tvalid && register_tready) begin
        replies_seen++;
        if (exp_q.size() == 0) begin
          $display("reply at %0t ns arrived with no read pending", $time);
          fail_count++;
        end else begin
          check_value(register_tdata, exp_q.pop_front(), "reply word");
        end
      end
      if (operation_tvalid && operation_tready) begin
        word = operation_tdata;
        if (word[`FILEREG_ENTRY_WIDTH+`FILEREG_ID_WIDTH] == `FILEREG_CMD_WRITE) begin
          model[word[`FILEREG_ENTRY_WIDTH +: `FILEREG_ID_WIDTH]] = word[`FILEREG_ENTRY_WIDTH-1:0];
        end else begin
          exp_q.push_back(expected_reply(word[`FILEREG_ENTRY_WIDTH +: `FILEREG_ID_WIDTH],
                                         word[`FILEREG_NODE_ID_WIDTH-1:0]));
          reads_seen++;
        end
      end
    end
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // hold the word until tready, count the stalled edges
  task automatic send_cmd(input cmd_t cmd, input entry_id_t id, input entry_t payload,
                          output int stall_cycles);
    stall_cycles = 0;
    operation_tvalid <= 1'b1;
    operation_tdata  <= {cmd, id, payload};
    if (random_ready) register_tready <= $random(seed);
    @(posedge clk);
    while (!operation_tready) begin
      stall_cycles++;
      if (random_ready) register_tready <= $random(seed);
      @(posedge clk);
    end
    operation_tvalid <= 1'b0;
  endtask

  // open the reply side and let every pending reply out
  task automatic wait_drained();
    random_ready = 1'b0;
    register_tready <= 1'b1;
    @(posedge clk);
    while (exp_q.size() != 0 || register_tvalid) @(posedge clk);
    @(posedge clk);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("test %s: %0d errors", name, fail_count - errs_before);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin : main_seq
    int     stall;
    int     errs;
    int     reads_before;
    entry_t val;
    entry_t old_val;
    operation_tvalid = 1'b0;
    operation_tdata  = '0;
    register_tready  = 1'b1;
    random_ready     = 1'b0;
    do @(posedge clk); while (rst);

    // 1. reset defaults on the bus and through reads
    errs = fail_count;
    check_value(lbdr_bits_bus, expected_bus(), "lbdr bus after reset");
    check_value(lbdr_bits_bus[LB-1:0], 12'h3cf, "xy default of an inner node");
    for (int i = 0; i < `FILEREG_DEPTH; i++) begin
      val = $random(seed);
      val[3:0] = i ^ 4'ha;
      send_cmd(`FILEREG_CMD_READ, entry_id_t'(i), val, stall);
    end
    wait_drained();
    finish_test("1 reset defaults", errs);

    // 2. write then read back each entry
    errs = fail_count;
    for (int i = 0; i < `FILEREG_DEPTH; i++) begin
      val = $random(seed);
      send_cmd(`FILEREG_CMD_WRITE, entry_id_t'(i), val, stall);
      check_value(stall, 0, "write stall cycles");
      send_cmd(`FILEREG_CMD_READ, entry_id_t'(i), entry_t'(i + 3), stall);
    end
    wait_drained();
    finish_test("2 write and read back", errs);

    // 3. vn writes reach the lbdr bus, top nibble cut off
    errs = fail_count;
    for (int vn = 0; vn < `FILEREG_NUM_VNS; vn++) begin
      val = $random(seed) | 16'hf000;
      send_cmd(`FILEREG_CMD_WRITE, entry_id_t'(vn), val, stall);
      @(posedge clk);
      check_value(lbdr_bits_bus[vn*LB +: LB], val[LB-1:0], "lbdr slice of written vn");
      check_value(lbdr_bits_bus, expected_bus(), "whole lbdr bus");
    end
    finish_test("3 lbdr bus update", errs);

    // 4. stalled reply keeps the value captured at accept
    errs = fail_count;
    old_val = model[2];
    register_tready <= 1'b0;
    send_cmd(`FILEREG_CMD_READ, 3'd2, 16'h0003, stall);
    send_cmd(`FILEREG_CMD_WRITE, 3'd2, 16'h1234, stall);
    check_value(stall, 0, "write behind a full slot");
    send_cmd(`FILEREG_CMD_WRITE, 3'd2, 16'hbeef, stall);
    check_value(stall, 0, "write behind a full slot");
    operation_tvalid <= 1'b1;
    operation_tdata  <= {`FILEREG_CMD_READ, 3'd2, 16'h0009};
    repeat (4) begin
      @(posedge clk);
      check_value(operation_tready, 1'b0, "second read ready while slot full");
      check_value(register_tvalid, 1'b1, "stalled reply valid");
    end
    register_tready <= 1'b1;
    @(posedge clk);
    // drain and refill in the same cycle
    check_value(operation_tready, 1'b1, "second read ready in drain cycle");
    check_value(register_tdata, {4'd3, old_val}, "held reply data");
    operation_tvalid <= 1'b0;
    wait_drained();
    finish_test("4 back-pressure", errs);

    // 5. random mix against random reply ready
    errs = fail_count;
    reads_before = reads_seen - replies_seen;
    random_ready = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      val = $random(seed);
      send_cmd(cmd_t'($random(seed)), entry_id_t'($random(seed)), val, stall);
    end
    wait_drained();
    check_value(reads_seen - replies_seen, reads_before, "replies lost or duplicated");
    finish_test("5 random mix", errs);

    if (exp_q.size() != 0) begin
      $display("%0d expected replies never came out of the DUT", exp_q.size());
      fail_count++;
    end
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (20 * PLANNED_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", 20 * PLANNED_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+common
common/filereg_pkg.sv
filereg/lbdr_xy_defaults.sv
filereg/filereg_array.sv
rtl/op_control.sv
rtl/read_return.sv
rtl/filereg_top.sv
tb/tb_clock_gen.sv
tb/tb_filereg.sv

//--- Bender.yml
package:
  name: filereg

sources:
  - include_dirs:
      - common
    files:
      - common/filereg_pkg.sv
      - filereg/lbdr_xy_defaults.sv
      - filereg/filereg_array.sv
      - rtl/op_control.sv
      - rtl/read_return.sv
      - rtl/filereg_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_filereg.sv
